//--- design/pe_array_pkg.sv
package pe_array_pkg;

`include "pe_array_config.svh"

    typedef logic [`PE_DATA_W-1:0] data_t;

    typedef logic [$clog2(`PE_COLS)-1:0] col_idx_t;

    // lane-wise operation of every PE
    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_mul,
        op_absdiff
    } pe_op_t;

    typedef enum logic [1:0] {
        mode_direct,
        mode_column,
        mode_row,
        mode_all
    } reduce_mode_t;

    typedef data_t     [`PE_LANES-1:0] lane_vec_t;
    typedef lane_vec_t [`PE_ROWS-1:0]  grid_vec_t;
    typedef data_t     [`PE_ROWS-1:0]  row_scalar_t;

endpackage

//--- design/pe_array_top.sv
`timescale 1ns/1ps

`include "pe_array_config.svh"

module pe_array_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  pe_array_pkg::col_idx_t     col_index,
    input  pe_array_pkg::pe_op_t       op,
    input  pe_array_pkg::reduce_mode_t mode,
    input  logic                       clear,
    input  pe_array_pkg::grid_vec_t    in_data,
    input  pe_array_pkg::grid_vec_t    par_data,
    output pe_array_pkg::row_scalar_t  scalar_out,
    output pe_array_pkg::grid_vec_t    vec_out,
    output logic                       out_valid
);
    import pe_array_pkg::*;

    // cell results indexed by column then row
    wire grid_vec_t   cell_lanes   [`PE_COLS];
    wire row_scalar_t cell_scalars [`PE_COLS];

    for (genvar c = 0; c < `PE_COLS; c++) begin : g_col
        for (genvar r = 0; r < `PE_ROWS; r++) begin : g_row
            pe_cell #(
                .col_id(c)
            ) i_pe_cell (
                .clk        (clk),
                .rst        (rst),
                .load       (load),
                .col_index  (col_index),
                .op         (op),
                .in_lanes   (in_data[r]),
                .par_lanes  (par_data[r]),
                .lane_out   (cell_lanes[c][r]),
                .scalar_out (cell_scalars[c][r])
            );
        end
    end

    sum_reducer i_sum_reducer (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .col_index    (col_index),
        .mode         (mode),
        .clear        (clear),
        .cell_lanes   (cell_lanes),
        .cell_scalars (cell_scalars),
        .scalar_out   (scalar_out),
        .vec_out      (vec_out),
        .out_valid    (out_valid)
    );

endmodule

//--- design/pe_cell.sv
`timescale 1ns/1ps

`include "pe_array_config.svh"

module pe_cell #(
    parameter int col_id = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  pe_array_pkg::col_idx_t  col_index,
    input  pe_array_pkg::pe_op_t    op,
    input  pe_array_pkg::lane_vec_t in_lanes,
    input  pe_array_pkg::lane_vec_t par_lanes,
    output pe_array_pkg::lane_vec_t lane_out,
    output pe_array_pkg::data_t     scalar_out
);
    import pe_array_pkg::*;

    logic      hit;
    lane_vec_t lane_next;
    data_t     total_next;

    // this cell owns one column of the shared load bus
    assign hit = load && (col_index == col_idx_t'(col_id));

    always_comb begin
        total_next = '0;
        for (int l = 0; l < `PE_LANES; l++) begin
            case (op)
                op_add: begin
                    lane_next[l] = in_lanes[l] + par_lanes[l];
                end
                op_sub: begin
                    lane_next[l] = in_lanes[l] - par_lanes[l];
                end
                op_mul: begin
                    // low half of the product only
                    lane_next[l] = in_lanes[l] * par_lanes[l];
                end
                op_absdiff: begin
                    if (in_lanes[l] >= par_lanes[l]) begin
                        lane_next[l] = in_lanes[l] - par_lanes[l];
                    end else begin
                        lane_next[l] = par_lanes[l] - in_lanes[l];
                    end
                end
                default: begin
                    lane_next[l] = '0;
                end
            endcase
            // scalar total wraps modulo 2^32
            total_next = total_next + lane_next[l];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lane_out   <= '0;
            scalar_out <= '0;
        end else if (hit) begin
            lane_out   <= lane_next;
            scalar_out <= total_next;
        end
    end

endmodule

//--- design/sum_reducer.sv
`timescale 1ns/1ps

`include "pe_array_config.svh"

module sum_reducer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  pe_array_pkg::col_idx_t     col_index,
    input  pe_array_pkg::reduce_mode_t mode,
    input  logic                       clear,
    input  pe_array_pkg::grid_vec_t    cell_lanes [`PE_COLS],
    input  pe_array_pkg::row_scalar_t  cell_scalars [`PE_COLS],
    output pe_array_pkg::row_scalar_t  scalar_out,
    output pe_array_pkg::grid_vec_t    vec_out,
    output logic                       out_valid
);
    import pe_array_pkg::*;

    logic         s1_valid;
    col_idx_t     s1_col;
    reduce_mode_t s1_mode;

    grid_vec_t    sel_lanes;
    row_scalar_t  sel_scalars;
    data_t        col_scalar;
    lane_vec_t    col_vec;

    row_scalar_t  acc_scalar;
    row_scalar_t  acc_scalar_next;
    grid_vec_t    acc_vec;
    grid_vec_t    acc_vec_next;
    data_t        all_scalar;
    lane_vec_t    all_vec;

    logic         last_col;
    int unsigned  slot;

    function automatic data_t scalar_total(row_scalar_t s);
        data_t t;
        t = '0;
        for (int r = 0; r < `PE_ROWS; r++) begin
            t = t + s[r];
        end
        return t;
    endfunction

    // lane-wise sum over the rows
    function automatic lane_vec_t lane_total(grid_vec_t v);
        lane_vec_t t;
        t = '0;
        for (int r = 0; r < `PE_ROWS; r++) begin
            for (int l = 0; l < `PE_LANES; l++) begin
                t[l] = t[l] + v[r][l];
            end
        end
        return t;
    endfunction

    // stage 1 lines up with the cell capture edge
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            s1_col   <= '0;
            s1_mode  <= mode_direct;
        end else begin
            s1_valid <= load && !clear;
            if (load) begin
                s1_col  <= col_index;
                s1_mode <= mode;
            end
        end
    end

    // cells hold their results, so the column can be picked a cycle late
    assign sel_lanes   = cell_lanes[s1_col];
    assign sel_scalars = cell_scalars[s1_col];

    assign col_scalar = scalar_total(sel_scalars);
    assign col_vec    = lane_total(sel_lanes);

    always_comb begin
        for (int r = 0; r < `PE_ROWS; r++) begin
            acc_scalar_next[r] = acc_scalar[r] + sel_scalars[r];
            for (int l = 0; l < `PE_LANES; l++) begin
                acc_vec_next[r][l] = acc_vec[r][l] + sel_lanes[r][l];
            end
        end
    end

    // grand totals include the column being added now
    assign all_scalar = scalar_total(acc_scalar_next);
    assign all_vec    = lane_total(acc_vec_next);

    assign last_col = (s1_col == col_idx_t'(`PE_COLS - 1));
    assign slot     = s1_col % `PE_ROWS;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc_scalar <= '0;
            acc_vec    <= '0;
            scalar_out <= '0;
            vec_out    <= '0;
            out_valid  <= 1'b0;
        end else if (clear) begin
            acc_scalar <= '0;
            acc_vec    <= '0;
            scalar_out <= '0;
            vec_out    <= '0;
            out_valid  <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (s1_valid) begin
                case (s1_mode)
                    mode_direct: begin
                        scalar_out <= sel_scalars;
                        vec_out    <= sel_lanes;
                        out_valid  <= 1'b1;
                    end
                    mode_column: begin
                        // other slots keep what they had
                        scalar_out[slot] <= col_scalar;
                        vec_out[slot]    <= col_vec;
                        out_valid        <= 1'b1;
                    end
                    mode_row: begin
                        acc_scalar <= acc_scalar_next;
                        acc_vec    <= acc_vec_next;
                        if (last_col) begin
                            scalar_out <= acc_scalar_next;
                            vec_out    <= acc_vec_next;
                            out_valid  <= 1'b1;
                        end
                    end
                    mode_all: begin
                        acc_scalar <= acc_scalar_next;
                        acc_vec    <= acc_vec_next;
                        if (last_col) begin
                            scalar_out[0] <= all_scalar;
                            vec_out[0]    <= all_vec;
                            out_valid     <= 1'b1;
                        end
                    end
                    default: begin
                        out_valid <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

//--- dv/pe_array_tb.sv
`timescale 1ns/1ps

`include "pe_array_config.svh"

module pe_array_tb;
    import pe_array_pkg::*;

    localparam int VALID_TIMEOUT = 20;

    logic         clk;
    logic         rst;
    logic         load;
    col_idx_t     col_index;
    pe_op_t       op;
    reduce_mode_t mode;
    logic         clear;
    grid_vec_t    in_data;
    grid_vec_t    par_data;
    row_scalar_t  scalar_out;
    grid_vec_t    vec_out;
    logic         out_valid;

    int          error_count;
    logic [31:0] rng_state;

    // reference model state
    grid_vec_t   col_lanes_m;
    row_scalar_t col_scalars_m;
    row_scalar_t acc_scalar_m;
    grid_vec_t   acc_vec_m;
    row_scalar_t exp_scalar;
    grid_vec_t   exp_vec;

    pe_array_top i_pe_array_top (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .col_index  (col_index),
        .op         (op),
        .mode       (mode),
        .clear      (clear),
        .in_data    (in_data),
        .par_data   (par_data),
        .scalar_out (scalar_out),
        .vec_out    (vec_out),
        .out_valid  (out_valid)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic data_t lane_op(pe_op_t o, data_t a, data_t b);
        logic [63:0] prod;
        case (o)
            op_add: return a + b;
            op_sub: return a - b;
            op_mul: begin
                prod = 64'(a) * 64'(b);
                return prod[31:0];
            end
            default: return (a > b) ? a - b : b - a;
        endcase
    endfunction

    function automatic data_t lanes_sum(lane_vec_t v);
        data_t t;
        t = '0;
        for (int l = 0; l < `PE_LANES; l++) begin
            t = t + v[l];
        end
        return t;
    endfunction

    task automatic report_and_finish();
        $display("closing report: %0d error(s)", error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // random operands for one column with model results in col_*_m
    task automatic drive_load(input col_idx_t c, input pe_op_t o, input reduce_mode_t m);
        for (int r = 0; r < `PE_ROWS; r++) begin
            for (int l = 0; l < `PE_LANES; l++) begin
                in_data[r][l]     = next_rand();
                par_data[r][l]    = next_rand();
                col_lanes_m[r][l] = lane_op(o, in_data[r][l], par_data[r][l]);
            end
            col_scalars_m[r] = lanes_sum(col_lanes_m[r]);
        end
        col_index = c;
        op        = o;
        mode      = m;
        load      = 1'b1;
    endtask

    task automatic update_model(input col_idx_t c, input reduce_mode_t m, output logic v);
        int slot;
        slot = int'(c) % `PE_ROWS;
        v    = 1'b1;
        case (m)
            mode_direct: begin
                exp_scalar = col_scalars_m;
                exp_vec    = col_lanes_m;
            end
            mode_column: begin
                exp_scalar[slot] = '0;
                exp_vec[slot]    = '0;
                for (int r = 0; r < `PE_ROWS; r++) begin
                    exp_scalar[slot] = exp_scalar[slot] + col_scalars_m[r];
                    for (int l = 0; l < `PE_LANES; l++) begin
                        exp_vec[slot][l] = exp_vec[slot][l] + col_lanes_m[r][l];
                    end
                end
            end
            default: begin
                for (int r = 0; r < `PE_ROWS; r++) begin
                    acc_scalar_m[r] = acc_scalar_m[r] + col_scalars_m[r];
                    for (int l = 0; l < `PE_LANES; l++) begin
                        acc_vec_m[r][l] = acc_vec_m[r][l] + col_lanes_m[r][l];
                    end
                end
                v = (int'(c) == `PE_COLS - 1);
                if (v && m == mode_row) begin
                    exp_scalar = acc_scalar_m;
                    exp_vec    = acc_vec_m;
                end else if (v) begin
                    // grand totals land in slot 0 only
                    exp_scalar[0] = '0;
                    exp_vec[0]    = '0;
                    for (int r = 0; r < `PE_ROWS; r++) begin
                        exp_scalar[0] = exp_scalar[0] + acc_scalar_m[r];
                        for (int l = 0; l < `PE_LANES; l++) begin
                            exp_vec[0][l] = exp_vec[0][l] + acc_vec_m[r][l];
                        end
                    end
                end
            end
        endcase
    endtask

    task automatic check_outputs();
        for (int r = 0; r < `PE_ROWS; r++) begin
            assert (scalar_out[r] === exp_scalar[r]) else begin
                $display("** Error: scalar_out[%0d] = %h, expected %h",
                         r, scalar_out[r], exp_scalar[r]);
                error_count++;
            end
            assert (vec_out[r] === exp_vec[r]) else begin
                $display("** Error: vec_out[%0d] = %h, expected %h", r, vec_out[r], exp_vec[r]);
                error_count++;
            end
        end
    endtask

    task automatic check_valid_low();
        assert (out_valid === 1'b0) else begin
            $display("** Error: out_valid = %h, expected 0", out_valid);
            error_count++;
        end
    endtask

    task automatic wait_valid(output int cycles);
        cycles = 0;
        while (out_valid !== 1'b1 && cycles < VALID_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (out_valid !== 1'b1) begin
            $display("timeout: out_valid never rose within %0d cycles", VALID_TIMEOUT);
            error_count++;
            $display("closing report: %0d error(s)", error_count);
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    // one load followed by the response window of that load
    task automatic run_load(input col_idx_t c, input pe_op_t o, input reduce_mode_t m);
        logic expect_valid;
        int   cycles;
        drive_load(c, o, m);
        update_model(c, m, expect_valid);
        @(negedge clk);
        load = 1'b0;
        check_valid_low();
        if (expect_valid) begin
            wait_valid(cycles);
            assert (cycles == 1) else begin
                $display("out_valid rose %0d edges after the load instead of 2", cycles + 1);
                error_count++;
            end
            check_outputs();
            @(negedge clk);
            check_valid_low();
        end else begin
            repeat (2) begin
                @(negedge clk);
                check_valid_low();
            end
            check_outputs();
        end
    endtask

    task automatic do_clear();
        clear = 1'b1;
        @(negedge clk);
        clear        = 1'b0;
        acc_scalar_m = '0;
        acc_vec_m    = '0;
        exp_scalar   = '0;
        exp_vec      = '0;
        check_valid_low();
        check_outputs();
    endtask

    task automatic test_reset_state();
        check_outputs();
        repeat (5) begin
            @(negedge clk);
            check_valid_low();
        end
    endtask

    task automatic test_direct();
        row_scalar_t first_scalar;
        grid_vec_t   first_vec;
        logic        v;
        for (int o = 0; o < 4; o++) begin
            for (int c = 0; c < `PE_COLS; c++) begin
                run_load(col_idx_t'(c), pe_op_t'(o), mode_direct);
            end
        end
        // two loads on consecutive cycles
        drive_load(col_idx_t'(0), pe_op_t'(next_rand() % 4), mode_direct);
        update_model(col_idx_t'(0), mode_direct, v);
        first_scalar = exp_scalar;
        first_vec    = exp_vec;
        @(negedge clk);
        drive_load(col_idx_t'(1), pe_op_t'(next_rand() % 4), mode_direct);
        update_model(col_idx_t'(1), mode_direct, v);
        @(negedge clk);
        load = 1'b0;
        assert (out_valid === 1'b1) else begin
            $display("** Error: out_valid = %h for first back-to-back load, expected 1", out_valid);
            error_count++;
        end
        exp_scalar = first_scalar;
        exp_vec    = first_vec;
        check_outputs();
        update_model(col_idx_t'(1), mode_direct, v);
        @(negedge clk);
        assert (out_valid === 1'b1) else begin
            $display("** Error: out_valid = %h for second back-to-back load, expected 1", out_valid);
            error_count++;
        end
        check_outputs();
        @(negedge clk);
        check_valid_low();
    endtask

    task automatic test_column();
        // reverse order so every slot is checked while others hold
        for (int c = `PE_COLS - 1; c >= 0; c--) begin
            run_load(col_idx_t'(c), pe_op_t'(next_rand() % 4), mode_column);
        end
    endtask

    task automatic test_accumulate(input reduce_mode_t m);
        do_clear();
        for (int c = 0; c < `PE_COLS; c++) begin
            run_load(col_idx_t'(c), pe_op_t'(next_rand() % 4), m);
        end
    endtask

    initial begin
        rng_state    = 32'hfdaf;
        error_count  = 0;
        rst          = 1'b0;
        load         = 1'b0;
        col_index    = '0;
        op           = op_add;
        mode         = mode_direct;
        clear        = 1'b0;
        in_data      = '0;
        par_data     = '0;
        acc_scalar_m = '0;
        acc_vec_m    = '0;
        exp_scalar   = '0;
        exp_vec      = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        test_reset_state();
        test_direct();
        test_column();
        test_accumulate(mode_row);
        test_accumulate(mode_all);
        // second run must not see the first run's data
        test_accumulate(mode_all);

        report_and_finish();
    end

endmodule

//--- include/pe_array_config.svh
`ifndef PE_ARRAY_CONFIG_SVH
`define PE_ARRAY_CONFIG_SVH

// grid geometry
`define PE_ROWS 4
`define PE_COLS 4

// lanes per PE and lane width
`define PE_LANES 4
`define PE_DATA_W 32

`endif

//--- pe_array.f
+incdir+include
design/pe_array_pkg.sv
design/pe_cell.sv
design/sum_reducer.sv
design/pe_array_top.sv
dv/pe_array_tb.sv
